/* sim.f */
+incdir+source
source/net_pkg.sv
source/echo_pkg.sv
source/echo_ifs.sv
source/echo_filter_fsm.sv
source/reply_header.sv
source/fifo_pointers.sv
source/payload_fifo.sv
source/udp_echo_top.sv
verification/tb_clock_gen.sv
verification/tb_udp_echo.sv

/* source/echo_cfg.svh */
`ifndef ECHO_CFG_SVH
`define ECHO_CFG_SVH

// UDP destination port that gets an echo reply
`define ECHO_PORT 1234

// Payload FIFO holds 2**FIFO_ADDR_BITS bytes
`define FIFO_ADDR_BITS 4

// Protocol field widths
`define PORT_BITS 16
`define IP_BITS 32
`define BYTE_BITS 8

`endif

/* source/echo_filter_fsm.sv */
`timescale 1ns/1ns
`include "echo_cfg.svh"

module echo_filter_fsm (
    input  logic          clk,
    input  logic          rst,
    udp_hdr_if.sink       hdr,
    byte_stream_if.sink   rx,
    byte_stream_if.source fwd,
    input  logic          reply_busy,
    output logic          load_reply
);

    echo_pkg::filter_state_t state_q;
    logic                    port_match;
    logic                    hdr_fire;
    logic                    rx_fire;

    assign port_match = (hdr.dst_port == net_pkg::udp_port_t'(`ECHO_PORT));

    // Headers only between frames; a matching one waits for a free reply slot
    assign hdr.ready = (state_q == echo_pkg::IDLE) && (!port_match || !reply_busy);
    assign hdr_fire  = hdr.valid && hdr.ready;
    assign load_reply = hdr_fire && port_match;

    // Payload goes to the FIFO in PASS, sunk in DROP
    assign fwd.data  = rx.data;
    assign fwd.last  = rx.last;
    assign fwd.user  = rx.user;
    assign fwd.valid = rx.valid && (state_q == echo_pkg::PASS);

    always_comb begin
        case (state_q)
            echo_pkg::PASS: rx.ready = fwd.ready;
            echo_pkg::DROP: rx.ready = 1'b1;
            default:        rx.ready = 1'b0;
        endcase
    end

    assign rx_fire = rx.valid && rx.ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= echo_pkg::IDLE;
        end else begin
            case (state_q)
                echo_pkg::IDLE: begin
                    if (hdr_fire) begin
                        state_q <= port_match ? echo_pkg::PASS : echo_pkg::DROP;
                    end
                end
                echo_pkg::PASS, echo_pkg::DROP: begin
                    if (rx_fire && rx.last) begin
                        state_q <= echo_pkg::IDLE;
                    end
                end
                default: state_q <= echo_pkg::IDLE;
            endcase
        end
    end

    // Reply slot was free at load and is taken on the next cycle
    a_load_slot: assert property (@(posedge clk) disable iff (rst)
        load_reply |-> !reply_busy ##1 (reply_busy && state_q == echo_pkg::PASS));

    // End of frame always brings the filter back to IDLE
    a_frame_end: assert property (@(posedge clk) disable iff (rst)
        (state_q != echo_pkg::IDLE && rx_fire && rx.last) |=> state_q == echo_pkg::IDLE);

endmodule

/* source/echo_ifs.sv */
`timescale 1ns/1ns

// Parsed UDP header with a valid/ready strobe
interface udp_hdr_if;
    logic               valid;
    logic               ready;
    net_pkg::ip_addr_t  ip;
    net_pkg::udp_port_t src_port;
    net_pkg::udp_port_t dst_port;
    net_pkg::udp_len_t  len;

    modport source (
        output valid, ip, src_port, dst_port, len,
        input  ready
    );

    modport sink (
        input  valid, ip, src_port, dst_port, len,
        output ready
    );
endinterface

// Byte stream, transfer on valid and ready both high
interface byte_stream_if;
    net_pkg::byte_t data;
    logic           valid;
    logic           ready;
    logic           last;
    logic           user;

    modport source (
        output data, valid, last, user,
        input  ready
    );

    modport sink (
        input  data, valid, last, user,
        output ready
    );
endinterface

/* source/echo_pkg.sv */
`include "echo_cfg.svh"

package echo_pkg;

    // Per-frame decision of the filter
    typedef enum logic [1:0] {IDLE, PASS, DROP} filter_state_t;

    // FIFO address with wrap bit on top
    typedef logic [`FIFO_ADDR_BITS:0] fifo_ptr_t;

    // Occupancy, 0 up to the full depth
    typedef logic [`FIFO_ADDR_BITS:0] fifo_count_t;

endpackage

/* source/fifo_pointers.sv */
`timescale 1ns/1ns
`include "echo_cfg.svh"

module fifo_pointers (
    input  logic                clk,
    input  logic                rst,
    input  logic                push,
    input  logic                pop,
    output echo_pkg::fifo_ptr_t wr_addr,
    output echo_pkg::fifo_ptr_t rd_addr,
    output logic                full,
    output logic                empty
);

    echo_pkg::fifo_ptr_t   wr_q;
    echo_pkg::fifo_ptr_t   rd_q;
    echo_pkg::fifo_count_t count_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_q    <= '0;
            rd_q    <= '0;
            count_q <= '0;
        end else begin
            if (push) begin
                wr_q <= wr_q + 1'b1;
            end
            if (pop) begin
                rd_q <= rd_q + 1'b1;
            end
            case ({push, pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    assign wr_addr = wr_q;
    assign rd_addr = rd_q;

    // Top bit alone marks the full depth
    assign full  = count_q[`FIFO_ADDR_BITS];
    assign empty = (count_q == '0);

    a_count_bound: assert property (@(posedge clk) disable iff (rst)
        !(count_q[`FIFO_ADDR_BITS] && |count_q[`FIFO_ADDR_BITS-1:0]));

    // Wrapped pointer distance and counter agree
    a_count_match: assert property (@(posedge clk) disable iff (rst)
        echo_pkg::fifo_count_t'(wr_q - rd_q) == count_q);

endmodule

/* source/net_pkg.sv */
`include "echo_cfg.svh"

package net_pkg;

    // One byte of UDP payload
    typedef logic [`BYTE_BITS-1:0] byte_t;

    // IPv4 address
    typedef logic [`IP_BITS-1:0] ip_addr_t;

    // UDP port number
    typedef logic [`PORT_BITS-1:0] udp_port_t;

    // UDP length field, same width as a port
    typedef logic [`PORT_BITS-1:0] udp_len_t;

endpackage

/* source/payload_fifo.sv */
`timescale 1ns/1ns
`include "echo_cfg.svh"

module payload_fifo (
    input  logic           clk,
    input  logic           rst,
    byte_stream_if.sink    wr,
    byte_stream_if.source  rd,
    output net_pkg::byte_t led
);

    // Each entry is {last, user, data}
    logic [`BYTE_BITS+1:0] mem [0:(1 << `FIFO_ADDR_BITS)-1];

    echo_pkg::fifo_ptr_t wr_addr;
    echo_pkg::fifo_ptr_t rd_addr;
    logic                full;
    logic                empty;
    logic                push;
    logic                pop;
    logic                seen_q;
    net_pkg::byte_t      led_q;

    fifo_pointers ptrs0 (
        .clk     (clk),
        .rst     (rst),
        .push    (push),
        .pop     (pop),
        .wr_addr (wr_addr),
        .rd_addr (rd_addr),
        .full    (full),
        .empty   (empty)
    );

    assign wr.ready = !full;
    assign push     = wr.valid && wr.ready;
    assign rd.valid = !empty;
    assign pop      = rd.valid && rd.ready;

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_addr[`FIFO_ADDR_BITS-1:0]] <= {wr.last, wr.user, wr.data};
        end
    end

    // Head entry read straight from the array
    assign {rd.last, rd.user, rd.data} = mem[rd_addr[`FIFO_ADDR_BITS-1:0]];

    // Catch the first byte of each outgoing frame
    always_ff @(posedge clk) begin
        if (rst) begin
            led_q  <= '0;
            seen_q <= 1'b0;
        end else begin
            if (rd.valid && !seen_q) begin
                led_q  <= rd.data;
                seen_q <= 1'b1;
            end
            if (pop && rd.last) begin
                seen_q <= 1'b0;
            end
        end
    end

    assign led = led_q;

    // Stalled write is held unchanged by the filter
    a_hold_full: assert property (@(posedge clk) disable iff (rst)
        (wr.valid && full) |=> (wr.valid && $stable({wr.last, wr.user, wr.data})));

endmodule

/* source/reply_header.sv */
`timescale 1ns/1ns

module reply_header (
    input  logic               clk,
    input  logic               rst,
    input  logic               load_reply,
    input  net_pkg::ip_addr_t  in_ip,
    input  net_pkg::udp_port_t in_src_port,
    input  net_pkg::udp_port_t in_dst_port,
    input  net_pkg::udp_len_t  in_len,
    output logic               reply_busy,
    udp_hdr_if.source          tx
);

    logic               valid_q;
    net_pkg::ip_addr_t  ip_q;
    net_pkg::udp_port_t src_port_q;
    net_pkg::udp_port_t dst_port_q;
    net_pkg::udp_len_t  len_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= 1'b0;
        end else if (load_reply) begin
            valid_q <= 1'b1;
        end else if (tx.ready) begin
            valid_q <= 1'b0;
        end
    end

    // Reply goes back to the sender, ports swapped
    always_ff @(posedge clk) begin
        if (load_reply) begin
            ip_q       <= in_ip;
            src_port_q <= in_dst_port;
            dst_port_q <= in_src_port;
            len_q      <= in_len;
        end
    end

    assign tx.valid    = valid_q;
    assign tx.ip       = ip_q;
    assign tx.src_port = src_port_q;
    assign tx.dst_port = dst_port_q;
    assign tx.len      = len_q;
    assign reply_busy  = valid_q;

    // Filter must hold a matching header until the slot is free
    a_no_overwrite: assert property (@(posedge clk) disable iff (rst)
        load_reply |-> !valid_q);

endmodule

/* source/udp_echo_top.sv */
`timescale 1ns/1ns

module udp_echo_top (
    input  logic               clk,
    input  logic               rst,

    // Incoming UDP header
    input  logic               rx_hdr_valid,
    output logic               rx_hdr_ready,
    input  net_pkg::ip_addr_t  rx_ip,
    input  net_pkg::udp_port_t rx_src_port,
    input  net_pkg::udp_port_t rx_dst_port,
    input  net_pkg::udp_len_t  rx_len,

    // Incoming payload
    input  net_pkg::byte_t     rx_data,
    input  logic               rx_valid,
    output logic               rx_ready,
    input  logic               rx_last,
    input  logic               rx_user,

    // Reply header
    output logic               tx_hdr_valid,
    input  logic               tx_hdr_ready,
    output net_pkg::ip_addr_t  tx_ip,
    output net_pkg::udp_port_t tx_src_port,
    output net_pkg::udp_port_t tx_dst_port,
    output net_pkg::udp_len_t  tx_len,

    // Reply payload
    output net_pkg::byte_t     tx_data,
    output logic               tx_valid,
    input  logic               tx_ready,
    output logic               tx_last,
    output logic               tx_user,

    output net_pkg::byte_t     led
);

    udp_hdr_if     rx_hdr_bus ();
    udp_hdr_if     tx_hdr_bus ();
    byte_stream_if rx_bus ();
    byte_stream_if fwd_bus ();
    byte_stream_if tx_bus ();

    logic reply_busy;
    logic load_reply;

    assign rx_hdr_bus.valid    = rx_hdr_valid;
    assign rx_hdr_bus.ip       = rx_ip;
    assign rx_hdr_bus.src_port = rx_src_port;
    assign rx_hdr_bus.dst_port = rx_dst_port;
    assign rx_hdr_bus.len      = rx_len;
    assign rx_hdr_ready        = rx_hdr_bus.ready;

    assign rx_bus.data  = rx_data;
    assign rx_bus.valid = rx_valid;
    assign rx_bus.last  = rx_last;
    assign rx_bus.user  = rx_user;
    assign rx_ready     = rx_bus.ready;

    assign tx_hdr_valid      = tx_hdr_bus.valid;
    assign tx_ip             = tx_hdr_bus.ip;
    assign tx_src_port       = tx_hdr_bus.src_port;
    assign tx_dst_port       = tx_hdr_bus.dst_port;
    assign tx_len            = tx_hdr_bus.len;
    assign tx_hdr_bus.ready  = tx_hdr_ready;

    assign tx_data      = tx_bus.data;
    assign tx_valid     = tx_bus.valid;
    assign tx_last      = tx_bus.last;
    assign tx_user      = tx_bus.user;
    assign tx_bus.ready = tx_ready;

    echo_filter_fsm filter0 (
        .clk        (clk),
        .rst        (rst),
        .hdr        (rx_hdr_bus),
        .rx         (rx_bus),
        .fwd        (fwd_bus),
        .reply_busy (reply_busy),
        .load_reply (load_reply)
    );

    // Header fields are sampled in the cycle of the load pulse
    reply_header reply0 (
        .clk         (clk),
        .rst         (rst),
        .load_reply  (load_reply),
        .in_ip       (rx_hdr_bus.ip),
        .in_src_port (rx_hdr_bus.src_port),
        .in_dst_port (rx_hdr_bus.dst_port),
        .in_len      (rx_hdr_bus.len),
        .reply_busy  (reply_busy),
        .tx          (tx_hdr_bus)
    );

    payload_fifo fifo0 (
        .clk (clk),
        .rst (rst),
        .wr  (fwd_bus),
        .rd  (tx_bus),
        .led (led)
    );

endmodule

/* verification/tb_clock_gen.sv */
`timescale 1ns/1ns

module tb_clock_gen (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Reset held over the first 8 rising edges
    initial begin
        rst = 1'b1;
        repeat (8) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

/* verification/tb_udp_echo.sv */
`timescale 1ns/1ns
`include "echo_cfg.svh"

module tb_udp_echo;

    localparam int frame_count = 60;
    localparam int wait_limit  = 2000;

    logic               clk;
    logic               rst;
    logic               rx_hdr_valid;
    logic               rx_hdr_ready;
    net_pkg::ip_addr_t  rx_ip;
    net_pkg::udp_port_t rx_src_port;
    net_pkg::udp_port_t rx_dst_port;
    net_pkg::udp_len_t  rx_len;
    net_pkg::byte_t     rx_data;
    logic               rx_valid;
    logic               rx_ready;
    logic               rx_last;
    logic               rx_user;
    logic               tx_hdr_valid;
    logic               tx_hdr_ready;
    net_pkg::ip_addr_t  tx_ip;
    net_pkg::udp_port_t tx_src_port;
    net_pkg::udp_port_t tx_dst_port;
    net_pkg::udp_len_t  tx_len;
    net_pkg::byte_t     tx_data;
    logic               tx_valid;
    logic               tx_ready;
    logic               tx_last;
    logic               tx_user;
    net_pkg::byte_t     led;

    logic [31:0] lfsr_state = 32'he5e97762;
    // Expected reply headers {ip, src_port, dst_port, len}
    logic [79:0] hdr_q [$];
    // Expected reply bytes {last, user, data}
    logic [9:0]  byte_q [$];
    int          stalls_seen = 0;

    tb_clock_gen clock0 (.clk(clk), .rst(rst));

    udp_echo_top dut0 (
        .clk          (clk),
        .rst          (rst),
        .rx_hdr_valid (rx_hdr_valid),
        .rx_hdr_ready (rx_hdr_ready),
        .rx_ip        (rx_ip),
        .rx_src_port  (rx_src_port),
        .rx_dst_port  (rx_dst_port),
        .rx_len       (rx_len),
        .rx_data      (rx_data),
        .rx_valid     (rx_valid),
        .rx_ready     (rx_ready),
        .rx_last      (rx_last),
        .rx_user      (rx_user),
        .tx_hdr_valid (tx_hdr_valid),
        .tx_hdr_ready (tx_hdr_ready),
        .tx_ip        (tx_ip),
        .tx_src_port  (tx_src_port),
        .tx_dst_port  (tx_dst_port),
        .tx_len       (tx_len),
        .tx_data      (tx_data),
        .tx_valid     (tx_valid),
        .tx_ready     (tx_ready),
        .tx_last      (tx_last),
        .tx_user      (tx_user),
        .led          (led)
    );

    // Galois form of x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] next_lfsr(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h80200003;
        end
        return s >> 1;
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] bits;
        bits = '0;
        for (int k = 0; k < n; k++) begin
            lfsr_state = next_lfsr(lfsr_state);
            bits = {bits[30:0], lfsr_state[0]};
        end
        return bits;
    endfunction

    task automatic stop_with_failure(input string what);
        $display("%s", what);
        $display("TB FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (expected === actual) else begin
            stop_with_failure($sformatf("FAIL %s expected %0h actual %0h",
                                        name, expected, actual));
        end
    endtask

    task automatic check_quiet_outputs(input string phase);
        check_value({phase, "_tx_hdr_valid"}, 0, tx_hdr_valid);
        check_value({phase, "_tx_valid"}, 0, tx_valid);
        check_value({phase, "_led"}, 0, led);
    endtask

    task automatic send_header(input net_pkg::ip_addr_t ip, input net_pkg::udp_port_t src,
                               input net_pkg::udp_port_t dst, input net_pkg::udp_len_t len);
        int waited;
        waited       = 0;
        rx_hdr_valid = 1'b1;
        rx_ip        = ip;
        rx_src_port  = src;
        rx_dst_port  = dst;
        rx_len       = len;
        #1;
        // Between frames a foreign port is taken at once
        if (dst != net_pkg::udp_port_t'(`ECHO_PORT)) begin
            check_value("drop_hdr_ready", 1, rx_hdr_ready);
        end
        while (!rx_hdr_ready) begin
            @(negedge clk);
            #1;
            waited++;
            if (waited > wait_limit) begin
                stop_with_failure("Timeout while waiting for rx_hdr_ready");
            end
        end
        // Reply goes back to the sender with the ports swapped
        if (dst == net_pkg::udp_port_t'(`ECHO_PORT)) begin
            hdr_q.push_back({ip, net_pkg::udp_port_t'(`ECHO_PORT), src, len});
        end
        @(negedge clk);
        rx_hdr_valid = 1'b0;
    endtask

    task automatic send_payload(input int nbytes, input logic echoes);
        int   waited;
        logic first_ready;
        for (int i = 0; i < nbytes; i++) begin
            // Occasional idle cycles between bytes
            if (take_bits(2) == 0) begin
                rx_valid = 1'b0;
                repeat (1 + take_bits(2)) @(negedge clk);
            end
            rx_valid = 1'b1;
            rx_data  = net_pkg::byte_t'(take_bits(8));
            rx_user  = take_bits(1);
            rx_last  = (i == nbytes - 1);
            waited   = 0;
            #1;
            first_ready = rx_ready;
            while (!rx_ready) begin
                @(negedge clk);
                #1;
                waited++;
                if (waited > wait_limit) begin
                    stop_with_failure("Timeout while waiting for rx_ready");
                end
            end
            if (echoes) begin
                byte_q.push_back({rx_last, rx_user, rx_data});
                if (!first_ready) begin
                    stalls_seen++;
                end
            end else begin
                check_value("drop_rx_ready", 1, first_ready);
            end
            @(negedge clk);
        end
        rx_valid = 1'b0;
        rx_last  = 1'b0;
    endtask

    task automatic send_frame();
        net_pkg::ip_addr_t  ip;
        net_pkg::udp_port_t src;
        net_pkg::udp_port_t dst;
        int                 nbytes;
        ip  = take_bits(32);
        src = net_pkg::udp_port_t'(take_bits(16));
        if (take_bits(1)) begin
            dst = net_pkg::udp_port_t'(`ECHO_PORT);
        end else begin
            dst = net_pkg::udp_port_t'(take_bits(16));
        end
        nbytes = 1 + (take_bits(6) % 40);
        // UDP length counts the 8 header bytes too
        send_header(ip, src, dst, net_pkg::udp_len_t'(nbytes + 8));
        send_payload(nbytes, dst == net_pkg::udp_port_t'(`ECHO_PORT));
    endtask

    initial begin : stimulus
        int waited;
        rx_hdr_valid = 1'b0;
        rx_ip        = '0;
        rx_src_port  = '0;
        rx_dst_port  = '0;
        rx_len       = '0;
        rx_data      = '0;
        rx_valid     = 1'b0;
        rx_last      = 1'b0;
        rx_user      = 1'b0;
        waited       = 0;
        @(posedge clk);
        while (rst) begin
            @(negedge clk);
            check_quiet_outputs("reset");
            waited++;
            if (waited > wait_limit) begin
                stop_with_failure("Timeout while waiting for reset to end");
            end
        end
        @(negedge clk);
        check_quiet_outputs("after_reset");
        for (int f = 0; f < frame_count; f++) begin
            send_frame();
        end
        waited = 0;
        while (hdr_q.size() != 0 || byte_q.size() != 0) begin
            @(negedge clk);
            waited++;
            if (waited > wait_limit) begin
                stop_with_failure("Timeout while waiting for the last replies");
            end
        end
        // Quiet period so stray replies still get caught
        repeat (20) @(negedge clk);
        check_value("hdr_queue_left", 0, hdr_q.size());
        check_value("byte_queue_left", 0, byte_q.size());
        assert (stalls_seen != 0) else begin
            stop_with_failure("The payload FIFO never filled up during the run");
        end
        $display("TB PASSED");
        $finish;
    end

    initial begin : reply_monitor
        logic [79:0]    exp_hdr;
        logic [9:0]     exp_byte;
        logic           hdr_take;
        logic           byte_take;
        logic           first_byte;
        logic           led_pending;
        net_pkg::byte_t led_expect;
        int             cycle;
        tx_hdr_ready = 1'b0;
        tx_ready     = 1'b0;
        first_byte   = 1'b1;
        led_pending  = 1'b0;
        led_expect   = '0;
        cycle        = 0;
        forever begin
            // Slow phases of back-pressure let the FIFO fill up
            @(posedge clk);
            cycle++;
            hdr_take  = cycle[6] ? (take_bits(2) == 0) : (take_bits(3) != 0);
            byte_take = cycle[6] ? (take_bits(2) == 0) : (take_bits(3) != 0);
            @(negedge clk);
            tx_hdr_ready = hdr_take;
            tx_ready     = byte_take;
            #1;
            if (led_pending) begin
                check_value("led_first_byte", led_expect, led);
                led_pending = 1'b0;
            end
            if (!rst && tx_hdr_valid && tx_hdr_ready) begin
                assert (hdr_q.size() != 0) else begin
                    stop_with_failure("A reply header came out with none expected");
                end
                exp_hdr = hdr_q.pop_front();
                check_value("reply_ip", exp_hdr[79:48], tx_ip);
                check_value("reply_src_port", exp_hdr[47:32], tx_src_port);
                check_value("reply_dst_port", exp_hdr[31:16], tx_dst_port);
                check_value("reply_len", exp_hdr[15:0], tx_len);
            end
            if (!rst && tx_valid && tx_ready) begin
                assert (byte_q.size() != 0) else begin
                    stop_with_failure("A reply byte came out with none expected");
                end
                exp_byte = byte_q.pop_front();
                check_value("reply_data", exp_byte[7:0], tx_data);
                check_value("reply_user", exp_byte[8], tx_user);
                check_value("reply_last", exp_byte[9], tx_last);
                if (first_byte) begin
                    led_pending = 1'b1;
                    led_expect  = exp_byte[7:0];
                end
                first_byte = exp_byte[9];
            end
        end
    end

endmodule
